/* verilog/chdr_pkg.sv */
// Shared types, field positions and sizes for the CHDR deframer.
// Imported by every RTL module and reused by the testbench for length rules.

package chdr_pkg;

   localparam int BEAT_W       = 64;
   localparam int WORD_W       = 32;
   localparam int HAS_TIME_BIT = 61;
   localparam int LEN_LSB      = 32;
   localparam int LEN_W        = 16;
   localparam int FIFO_ADDR_W  = 5;
   localparam int FIFO_DEPTH   = 1 << FIFO_ADDR_W;

   // One 64-bit stream beat with its end-of-packet marker.
   typedef struct packed
   {
      logic [BEAT_W-1:0] data;
      logic              last;
   } chdr_beat_t;

   // Header in the upper half, timestamp (or header again) in the lower half.
   typedef logic [2*BEAT_W-1:0] chdr_tuser_t;

   typedef enum logic [1:0]
   {
      st_head = 2'd0,
      st_time = 2'd1,
      st_body = 2'd2
   } chdr_state_t;

   // True when the final body beat holds a single 32-bit word.
   function automatic logic tail_is_half(input logic [LEN_W-1:0] len);
      logic [2:0] rem;
      begin
         rem = len[2:0];
         tail_is_half = (rem >= 3'd1) && (rem <= 3'd4);
      end
   endfunction

endpackage

/* verilog/chdr_stream_fifo.sv */
// Synchronous valid/ready queue used for both the header and the body path.
// Payload type is chosen by the T parameter; depth comes from FIFO_ADDR_W.
// Data written on one edge is readable after the next edge.

`timescale 1ns/100ps

module chdr_stream_fifo
   import chdr_pkg::*;
#(
   parameter type T = chdr_beat_t
)
(
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_clear,

   input  T     i_data,
   input  logic i_valid,
   output logic o_ready,

   output T     o_data,
   output logic o_valid,
   input  logic i_ready
);

   T                       mem [FIFO_DEPTH];
   logic [FIFO_ADDR_W-1:0] wr_ptr;
   logic [FIFO_ADDR_W-1:0] rd_ptr;
   logic [FIFO_ADDR_W:0]   count;
   logic [FIFO_ADDR_W:0]   count_nxt;
   logic                   valid_q;
   logic                   push;
   logic                   pop;

   assign o_ready = ~count[FIFO_ADDR_W];   // MSB set only at FIFO_DEPTH.
   assign o_valid = valid_q;
   assign o_data  = mem[rd_ptr];

   assign push = i_valid & o_ready;
   assign pop  = valid_q & i_ready;

   always_comb
   begin
      count_nxt = count;
      if (push && !pop)
      begin
         count_nxt = count + 1'b1;
      end
      else if (pop && !push)
      begin
         count_nxt = count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n || i_clear)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         valid_q <= 1'b0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count   <= count_nxt;
         valid_q <= (count_nxt != '0);
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= i_data;
      end
   end

   // Equal pointers on a write mean the queue is empty, never full.
   a_no_write_full : assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
      push |-> (wr_ptr != rd_ptr) || (count == '0));

   // Equal pointers on a read mean the queue is full, never empty.
   a_no_read_empty : assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
      pop |-> (wr_ptr != rd_ptr) || count[FIFO_ADDR_W]);

endmodule

/* verilog/chdr_header_parser.sv */
// Input stage of the deframer. Splits each packet into its header entry
// (header plus optional timestamp) and its body beats, one queue each.
// Purely combinational on the data path; only the FSM and held header are flops.

`timescale 1ns/100ps

module chdr_header_parser
   import chdr_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_clear,

   input  logic [BEAT_W-1:0] i_tdata,
   input  logic              i_tlast,
   input  logic              i_tvalid,
   output logic              o_tready,

   output chdr_tuser_t       o_hdr_tuser,
   output logic              o_hdr_valid,
   input  logic              i_hdr_ready,

   output chdr_beat_t        o_body_beat,
   output logic              o_body_valid,
   input  logic              i_body_ready
);

   chdr_state_t       state;
   logic [BEAT_W-1:0] head_q;         // Header waiting for its timestamp.
   logic              has_time;
   logic              hdr_take;
   logic              body_take;

   assign has_time = i_tdata[HAS_TIME_BIT];

   // In st_head the lower half is a copy, overwritten later if a timestamp follows.
   assign o_hdr_tuser = (state == st_head) ? {i_tdata, i_tdata} : {head_q, i_tdata};

   always_comb
   begin
      case (state)
         st_head : o_hdr_valid = i_tvalid & ~has_time;
         st_time : o_hdr_valid = i_tvalid;
         default : o_hdr_valid = 1'b0;
      endcase
   end

   assign o_body_beat.data = i_tdata;
   assign o_body_beat.last = i_tlast;
   assign o_body_valid     = (state == st_body) & i_tvalid;

   assign o_tready = (state == st_body) ? i_body_ready : i_hdr_ready;

   assign hdr_take  = i_tvalid & i_hdr_ready;
   assign body_take = i_tvalid & i_body_ready;

   always_ff @(posedge clk)
   begin
      if (!i_rst_n || i_clear)
      begin
         state <= st_head;
      end
      else
      begin
         case (state)
            st_head :
               if (hdr_take)
               begin
                  state <= has_time ? st_time : st_body;
               end
            st_time :
               if (hdr_take)
               begin
                  state <= st_body;
               end
            st_body :
               if (body_take && i_tlast)
               begin
                  state <= st_head;
               end
            default :
               state <= st_head;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == st_head && hdr_take && has_time)
      begin
         head_q <= i_tdata;
      end
   end

   // Body beats only flow once the header entry has gone out.
   a_body_in_body_state : assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
      $rose(state == st_body) |-> $past(o_hdr_valid && i_hdr_ready));

endmodule

/* verilog/chdr_beat_narrower.sv */
// Output stage of the deframer. Pairs each body beat with its header entry
// and sends it as 32-bit words, upper half first, with the user field alongside.
// Pops a body beat after its last word and the header after the packet's last word.

`timescale 1ns/100ps

module chdr_beat_narrower
   import chdr_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_clear,

   input  chdr_tuser_t       i_hdr_tuser,
   input  logic              i_hdr_valid,
   output logic              o_hdr_ready,

   input  chdr_beat_t        i_body_beat,
   input  logic              i_body_valid,
   output logic              o_body_ready,

   output logic [WORD_W-1:0] o_tdata,
   output chdr_tuser_t       o_tuser,
   output logic              o_tlast,
   output logic              o_tvalid,
   input  logic              i_tready
);

   logic             second_half;
   logic [LEN_W-1:0] pkt_len;
   logic             half_tail;
   logic             xfer;

   // Length sits in the header copy held in the upper half.
   assign pkt_len   = i_hdr_tuser[BEAT_W+LEN_LSB +: LEN_W];
   assign half_tail = tail_is_half(pkt_len);

   assign o_tdata  = second_half ? i_body_beat.data[WORD_W-1:0]
                                 : i_body_beat.data[BEAT_W-1:WORD_W];
   assign o_tuser  = i_hdr_tuser;
   assign o_tvalid = i_hdr_valid & i_body_valid;
   assign o_tlast  = i_body_beat.last & (second_half | half_tail);

   assign xfer = o_tvalid & i_tready;

   assign o_hdr_ready  = xfer & o_tlast;
   assign o_body_ready = xfer & (o_tlast | second_half);

   always_ff @(posedge clk)
   begin
      if (!i_rst_n || i_clear)
      begin
         second_half <= 1'b0;
      end
      else if (xfer)
      begin
         if (o_tlast)
         begin
            second_half <= 1'b0;   // Next packet starts on upper word.
         end
         else
         begin
            second_half <= ~second_half;
         end
      end
   end

   // Held words must not change while the sink stalls.
   a_out_stable : assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
      o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tuser)
                                && $stable(o_tlast));

endmodule

/* verilog/chdr_deframer_top.sv */
// Top level of the CHDR deframer. Takes 64-bit packet beats and returns
// 32-bit body words with the 128-bit header/timestamp user field.
// Parser feeds two queues; the narrower drains them in step.

`timescale 1ns/100ps

module chdr_deframer_top
   import chdr_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_clear,

   input  logic [BEAT_W-1:0] i_tdata,
   input  logic              i_tlast,
   input  logic              i_tvalid,
   output logic              o_tready_in,

   output logic [WORD_W-1:0] o_tdata,
   output chdr_tuser_t       o_tuser,
   output logic              o_tlast,
   output logic              o_tvalid,
   input  logic              i_tready_out
);

   chdr_tuser_t hdr_in_tuser;
   logic        hdr_in_valid;
   logic        hdr_in_ready;
   chdr_tuser_t hdr_out_tuser;
   logic        hdr_out_valid;
   logic        hdr_out_ready;

   chdr_beat_t  body_in_beat;
   logic        body_in_valid;
   logic        body_in_ready;
   chdr_beat_t  body_out_beat;
   logic        body_out_valid;
   logic        body_out_ready;

   chdr_header_parser parser0
   (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_clear      (i_clear),
      .i_tdata      (i_tdata),
      .i_tlast      (i_tlast),
      .i_tvalid     (i_tvalid),
      .o_tready     (o_tready_in),
      .o_hdr_tuser  (hdr_in_tuser),
      .o_hdr_valid  (hdr_in_valid),
      .i_hdr_ready  (hdr_in_ready),
      .o_body_beat  (body_in_beat),
      .o_body_valid (body_in_valid),
      .i_body_ready (body_in_ready)
   );

   chdr_stream_fifo #(.T(chdr_tuser_t)) hdr_fifo0
   (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_clear (i_clear),
      .i_data  (hdr_in_tuser),
      .i_valid (hdr_in_valid),
      .o_ready (hdr_in_ready),
      .o_data  (hdr_out_tuser),
      .o_valid (hdr_out_valid),
      .i_ready (hdr_out_ready)
   );

   chdr_stream_fifo #(.T(chdr_beat_t)) body_fifo0
   (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_clear (i_clear),
      .i_data  (body_in_beat),
      .i_valid (body_in_valid),
      .o_ready (body_in_ready),
      .o_data  (body_out_beat),
      .o_valid (body_out_valid),
      .i_ready (body_out_ready)
   );

   chdr_beat_narrower narrower0
   (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_clear      (i_clear),
      .i_hdr_tuser  (hdr_out_tuser),
      .i_hdr_valid  (hdr_out_valid),
      .o_hdr_ready  (hdr_out_ready),
      .i_body_beat  (body_out_beat),
      .i_body_valid (body_out_valid),
      .o_body_ready (body_out_ready),
      .o_tdata      (o_tdata),
      .o_tuser      (o_tuser),
      .o_tlast      (o_tlast),
      .o_tvalid     (o_tvalid),
      .i_tready     (i_tready_out)
   );

endmodule

/* testbench/tb_chdr_checks.svh */
// Result checks for the deframer testbench, included inside the testbench module.
// Each kind of result has its own compare task and its own error counter.

`ifndef TB_CHDR_CHECKS_SVH
`define TB_CHDR_CHECKS_SVH

int word_errs  = 0;
int last_errs  = 0;
int tuser_errs = 0;
int flag_errs  = 0;
int other_errs = 0;

task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                          input logic [WORD_W-1:0] want);
   if (got !== want)
   begin
      word_errs++;
      $display("FAILED %s at %0t: got %08h, expected %08h", name, $time, got, want);
   end
endtask

task automatic check_last(input string name, input logic got, input logic want);
   if (got !== want)
   begin
      last_errs++;
      $display("FAILED %s at %0t: got %0h, expected %0h", name, $time, got, want);
   end
endtask

task automatic check_tuser(input string name, input chdr_tuser_t got,
                           input chdr_tuser_t want);
   if (got !== want)
   begin
      tuser_errs++;
      $display("FAILED %s at %0t: got %032h, expected %032h", name, $time, got, want);
   end
endtask

// Control outputs such as valid and ready.
task automatic check_flag(input string name, input logic got, input logic want);
   if (got !== want)
   begin
      flag_errs++;
      $display("FAILED %s at %0t: got %0h, expected %0h", name, $time, got, want);
   end
endtask

function automatic int error_total();
   return word_errs + last_errs + tuser_errs + flag_errs + other_errs;
endfunction

`endif

/* testbench/tb_chdr_deframer.sv */
// Testbench for the CHDR deframer. Sends a table of packets with random
// headers and body words, and checks every output word against a queue of expected words.
// Output ready is throttled per packet, and one packet is flushed with a clear.

`timescale 1ns/100ps

module tb_chdr_deframer
   import chdr_pkg::*;
;

   localparam logic [1:0] MODE_FULL  = 2'd0;   // Ready always high.
   localparam logic [1:0] MODE_RAND  = 2'd1;   // Ready high half the time.
   localparam logic [1:0] MODE_SLOW  = 2'd2;   // Ready high one cycle in 16.
   localparam logic [1:0] MODE_FLUSH = 2'd3;   // Ready low, packet cleared.

   typedef struct packed
   {
      logic        has_time;
      logic [3:0]  words;
      logic [63:0] tstamp;
      logic [15:0] seq;
      logic [1:0]  mode;
   } pkt_t;

   typedef struct packed
   {
      logic [WORD_W-1:0] word;
      logic              last;
      chdr_tuser_t       tuser;
   } exp_t;

   localparam int NUM_PKTS = 17;
   localparam pkt_t PKT_TAB [NUM_PKTS] = '{
      '{1'b0, 4'd4,  64'h0,                   16'h0001, MODE_FULL},
      '{1'b1, 4'd3,  64'h1111_2222_3333_4444, 16'h0002, MODE_FULL},
      '{1'b0, 4'd1,  64'h0,                   16'h0003, MODE_FULL},
      '{1'b1, 4'd1,  64'h0A0B_0C0D_0E0F_1011, 16'h0004, MODE_FULL},
      '{1'b1, 4'd12, 64'h5555_6666_7777_8888, 16'h0005, MODE_RAND},
      '{1'b0, 4'd7,  64'h0,                   16'h0006, MODE_RAND},
      '{1'b1, 4'd5,  64'hDEAD_BEEF_0000_0007, 16'h0007, MODE_RAND},
      '{1'b1, 4'd12, 64'h0000_0001_0000_0008, 16'h0008, MODE_SLOW},
      '{1'b0, 4'd12, 64'h0,                   16'h0009, MODE_SLOW},
      '{1'b1, 4'd11, 64'h0000_0002_0000_000A, 16'h000A, MODE_SLOW},
      '{1'b0, 4'd12, 64'h0,                   16'h000B, MODE_SLOW},
      '{1'b1, 4'd12, 64'h0000_0003_0000_000C, 16'h000C, MODE_SLOW},
      '{1'b0, 4'd10, 64'h0,                   16'h000D, MODE_SLOW},
      '{1'b1, 4'd9,  64'h0000_0004_0000_000E, 16'h000E, MODE_SLOW},
      '{1'b0, 4'd6,  64'h0,                   16'h000F, MODE_FLUSH},
      '{1'b1, 4'd2,  64'hCAFE_F00D_1234_5678, 16'h0010, MODE_FULL},
      '{1'b0, 4'd9,  64'h0,                   16'h0011, MODE_RAND}
   };

   logic              clk;
   logic              i_rst_n;
   logic              i_clear;
   logic [BEAT_W-1:0] i_tdata;
   logic              i_tlast;
   logic              i_tvalid;
   logic              o_tready_in;
   logic [WORD_W-1:0] o_tdata;
   chdr_tuser_t       o_tuser;
   logic              o_tlast;
   logic              o_tvalid;
   logic              i_tready_out;

   integer            seed = 32'h8903;
   logic [1:0]        cur_mode = MODE_FULL;
   logic              saw_stall = 1'b0;   // Input ready seen low with a beat waiting.
   exp_t              exp_q [$];

   `include "tb_chdr_checks.svh"

   chdr_deframer_top dut0
   (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_clear      (i_clear),
      .i_tdata      (i_tdata),
      .i_tlast      (i_tlast),
      .i_tvalid     (i_tvalid),
      .o_tready_in  (o_tready_in),
      .o_tdata      (o_tdata),
      .o_tuser      (o_tuser),
      .o_tlast      (o_tlast),
      .o_tvalid     (o_tvalid),
      .i_tready_out (i_tready_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic int total_words();
      int sum;
      sum = 0;
      for (int k = 0; k < NUM_PKTS; k++)
      begin
         sum += int'(PKT_TAB[k].words);
      end
      return sum;
   endfunction

   // Called 10 ns after a rising edge; returns 10 ns after the accepting edge.
   task automatic send_beat(input logic [BEAT_W-1:0] data, input logic last);
      logic taken;
      i_tdata  = data;
      i_tlast  = last;
      i_tvalid = 1'b1;
      taken    = 1'b0;
      while (!taken)
      begin
         @(negedge clk);
         taken = o_tready_in;
         if (!taken)
         begin
            saw_stall = 1'b1;
         end
         @(posedge clk);
         #10;
      end
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0)
      begin
         @(posedge clk);
         #10;
      end
   endtask

   initial
   begin : ready_driver
      logic [31:0] r;
      i_tready_out = 1'b0;
      forever
      begin
         @(posedge clk);
         #10;
         r = $random(seed);
         case (cur_mode)
            MODE_FULL : i_tready_out = 1'b1;
            MODE_RAND : i_tready_out = r[0];
            MODE_SLOW : i_tready_out = (r[3:0] == 4'd0);
            default   : i_tready_out = 1'b0;
         endcase
      end
   end

   // Samples mid-cycle; a transfer completes on the following rising edge.
   initial
   begin : monitor
      exp_t e;
      forever
      begin
         @(negedge clk);
         if (i_rst_n && o_tvalid && i_tready_out)
         begin
            if (exp_q.size() == 0)
            begin
               other_errs++;
               $display("Output word %08h arrived with no packet pending", o_tdata);
            end
            else
            begin
               e = exp_q.pop_front();
               check_word("o_tdata", o_tdata, e.word);
               check_last("o_tlast", o_tlast, e.last);
               check_tuser("o_tuser", o_tuser, e.tuser);
            end
         end
      end
   end

   initial
   begin : watchdog
      int limit;
      limit = 200 * total_words() + 1000;
      repeat (limit) @(posedge clk);
      $display("Timeout after %0d cycles, %0d words never came out", limit, exp_q.size());
      $display("Regression failed");
      $finish;
   end

   initial
   begin : stimulus
      pkt_t              p;
      exp_t              e;
      logic [BEAT_W-1:0] hdr;
      logic [LEN_W-1:0]  len;
      logic [31:0]       r0;
      logic [31:0]       r1;
      logic [31:0]       w [12];
      int                nbeats;
      i_rst_n  = 1'b0;
      i_clear  = 1'b0;
      i_tdata  = '0;
      i_tlast  = 1'b0;
      i_tvalid = 1'b0;
      repeat (5) @(posedge clk);
      #10;
      i_rst_n = 1'b1;
      @(negedge clk);
      check_flag("o_tvalid", o_tvalid, 1'b0);
      check_flag("o_tlast", o_tlast, 1'b0);
      check_flag("o_tready_in", o_tready_in, 1'b1);
      @(posedge clk);
      #10;

      for (int n = 0; n < NUM_PKTS; n++)
      begin
         p = PKT_TAB[n];
         if (p.mode == MODE_FLUSH)
         begin
            wait_drained();   // Earlier packets must not be caught by the clear.
         end
         cur_mode = p.mode;

         // Header bytes, timestamp bytes, then 4 bytes per body word.
         len = 16'd8 + (p.has_time ? 16'd8 : 16'd0) + {10'd0, p.words, 2'b00};
         r0  = $random(seed);
         r1  = $random(seed);
         hdr = {r0, r1};
         hdr[HAS_TIME_BIT]     = p.has_time;
         hdr[LEN_LSB +: LEN_W] = len;
         hdr[15:0]             = p.seq;
         for (int k = 0; k < 12; k++)
         begin
            w[k] = $random(seed);   // Spare words fill the unused lower half.
         end
         nbeats = (int'(p.words) + 1) / 2;

         if (p.mode != MODE_FLUSH)
         begin
            for (int k = 0; k < int'(p.words); k++)
            begin
               e.word  = w[k];
               e.last  = (k == int'(p.words) - 1);
               e.tuser = p.has_time ? {hdr, p.tstamp} : {hdr, hdr};
               exp_q.push_back(e);
            end
         end
         else
         begin
            repeat (2) @(posedge clk);
            #10;
         end

         send_beat(hdr, 1'b0);
         if (p.has_time)
         begin
            send_beat(p.tstamp, 1'b0);
         end
         for (int b = 0; b < nbeats; b++)
         begin
            send_beat({w[2*b], w[2*b+1]}, b == nbeats - 1);
         end
         i_tvalid = 1'b0;
         i_tlast  = 1'b0;

         if (p.mode == MODE_FLUSH)
         begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_flag("o_tvalid", o_tvalid, 1'b1);   // Packet is waiting to go out.
            @(posedge clk);
            #10;
            i_clear = 1'b1;
            @(posedge clk);
            #10;
            i_clear = 1'b0;
            @(negedge clk);
            check_flag("o_tvalid", o_tvalid, 1'b0);
            check_flag("o_tready_in", o_tready_in, 1'b1);
            @(posedge clk);
            #10;
         end
      end

      cur_mode = MODE_FULL;
      wait_drained();
      repeat (10) @(posedge clk);
      @(negedge clk);
      check_flag("o_tvalid", o_tvalid, 1'b0);
      if (!saw_stall)
      begin
         other_errs++;
         $display("Input ready never dropped while the output was throttled");
      end

      $display("Errors: word %0d, last %0d, tuser %0d, flag %0d, other %0d",
               word_errs, last_errs, tuser_errs, flag_errs, other_errs);
      if (error_total() == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+testbench
verilog/chdr_pkg.sv
verilog/chdr_stream_fifo.sv
verilog/chdr_header_parser.sv
verilog/chdr_beat_narrower.sv
verilog/chdr_deframer_top.sv
testbench/tb_chdr_deframer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_chdr_deframer
FILELIST  = verilog.f
OBJDIR    = obj_dir
PASS_MSG  = Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
